/* sim/decodeVectors.svh */
/*
 * Decode test table: instruction words, program counters and the expected
 * class flags, branch condition, access size, immediate and branch target
 */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns: word, pc, flags, condition, size, immediate, target
// Flags: {alu mem load}_{unsigned flow sys}_{illegal writesRd usesImm}
// Condition and target are compared on flow rows only, size on memory rows only
task automatic loadVectors();
	// R2 words, one per listed function code, all with a nonzero rd
	addVec(r2Word(FN_ADD, 1, 2, 3), 'h100, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SUB, 4, 5, 6), 'h104, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_CMP, 7, 8, 9), 'h108, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_MUL, 10, 11, 12), 'h10c, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_MULU, 13, 14, 15), 'h110, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_DIV, 16, 17, 18), 'h114, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_DIVU, 19, 20, 21), 'h118, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_AND, 22, 23, 24), 'h11c, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_OR, 25, 26, 27), 'h120, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_EOR, 28, 29, 30), 'h124, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_ANDC, 31, 32, 33), 'h128, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_NAND, 34, 35, 36), 'h12c, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_NOR, 37, 38, 39), 'h130, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_ENOR, 40, 41, 42), 'h134, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_ORC, 43, 44, 45), 'h138, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SEQ, 46, 47, 48), 'h13c, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SNE, 49, 50, 51), 'h140, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SLT, 52, 53, 54), 'h144, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SLE, 55, 56, 57), 'h148, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SLTU, 58, 59, 60), 'h14c, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(r2Word(FN_SLEU, 61, 62, 63), 'h150, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	// Unlisted function code is not ALU work and so comes out illegal
	addVec(r2Word(7'd100, 0, 1, 2), 'h154, 9'b000_000_100, COND_EQ, SIZE_BYTE, 0, 0);

	// Immediate ALU forms, including the largest and smallest 13-bit values
	addVec(immWord(OP_ADDI, 1, 2, 100), 'h200, 9'b100_000_011, COND_EQ, SIZE_BYTE, 100, 0);
	addVec(immWord(OP_SUBFI, 3, 4, 77), 'h204, 9'b100_000_011, COND_EQ, SIZE_BYTE, 77, 0);
	addVec(immWord(OP_CMPI, 5, 6, 4095), 'h208, 9'b100_000_011, COND_EQ, SIZE_BYTE, 4095, 0);
	addVec(immWord(OP_MULI, 7, 8, 3), 'h20c, 9'b100_000_011, COND_EQ, SIZE_BYTE, 3, 0);
	addVec(immWord(OP_DIVI, 9, 10, 12), 'h210, 9'b100_000_011, COND_EQ, SIZE_BYTE, 12, 0);
	addVec(immWord(OP_ANDI, 11, 12, -4096), 'h214, 9'b100_000_011, COND_EQ, SIZE_BYTE, -4096, 0);
	addVec(immWord(OP_ORI, 13, 14, 255), 'h218, 9'b100_000_011, COND_EQ, SIZE_BYTE, 255, 0);
	addVec(immWord(OP_EORI, 15, 16, -1), 'h21c, 9'b100_000_011, COND_EQ, SIZE_BYTE, -1, 0);
	addVec(immWord(OP_SLTI, 17, 18, -300), 'h220, 9'b100_000_011, COND_EQ, SIZE_BYTE, -300, 0);
	addVec(immWord(OP_SHIFT, 19, 20, 5), 'h224, 9'b100_000_011, COND_EQ, SIZE_BYTE, 5, 0);
	// rd of zero never writes
	addVec(immWord(OP_ADDI, 0, 21, -5), 'h228, 9'b100_000_001, COND_EQ, SIZE_BYTE, -5, 0);
	// CSR and MOV write rd but the immediate field is ignored
	addVec(immWord(OP_CSR, 23, 24, 1234), 'h22c, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(immWord(OP_MOV, 25, 26, 9), 'h230, 9'b100_000_010, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(immWord(OP_NOP, 5, 0, 0), 'h234, 9'b100_000_000, COND_EQ, SIZE_BYTE, 0, 0);

	// Loads, signed and U forms of every size
	addVec(immWord(OP_LDB, 1, 2, 8), 'h300, 9'b111_000_011, COND_EQ, SIZE_BYTE, 8, 0);
	addVec(immWord(OP_LDBU, 3, 4, -8), 'h304, 9'b111_100_011, COND_EQ, SIZE_BYTE, -8, 0);
	addVec(immWord(OP_LDW, 5, 6, 16), 'h308, 9'b111_000_011, COND_EQ, SIZE_WYDE, 16, 0);
	addVec(immWord(OP_LDWU, 7, 8, 18), 'h30c, 9'b111_100_011, COND_EQ, SIZE_WYDE, 18, 0);
	addVec(immWord(OP_LDT, 9, 10, -32), 'h310, 9'b111_000_011, COND_EQ, SIZE_TETRA, -32, 0);
	addVec(immWord(OP_LDTU, 11, 12, 40), 'h314, 9'b111_100_011, COND_EQ, SIZE_TETRA, 40, 0);
	addVec(immWord(OP_LDO, 13, 14, 64), 'h318, 9'b111_000_011, COND_EQ, SIZE_OCTA, 64, 0);
	addVec(immWord(OP_LDA, 15, 16, -4096), 'h31c, 9'b111_100_011, COND_EQ, SIZE_OCTA, -4096, 0);
	addVec(immWord(OP_LDB, 0, 17, 1), 'h320, 9'b111_000_001, COND_EQ, SIZE_BYTE, 1, 0);

	// Stores use the immediate but write no register
	addVec(immWord(OP_STB, 20, 21, 4), 'h400, 9'b110_000_001, COND_EQ, SIZE_BYTE, 4, 0);
	addVec(immWord(OP_STW, 22, 23, -2), 'h404, 9'b110_000_001, COND_EQ, SIZE_WYDE, -2, 0);
	addVec(immWord(OP_STT, 24, 25, 100), 'h408, 9'b110_000_001, COND_EQ, SIZE_TETRA, 100, 0);
	addVec(immWord(OP_STO, 26, 27, 2000), 'h40c, 9'b110_000_001, COND_EQ, SIZE_OCTA, 2000, 0);

	// Branches, target is pc plus four times the displacement
	addVec(branchWord(OP_BEQ, 1, 2, 16), 'h2000, 9'b000_010_000, COND_EQ, SIZE_BYTE, 0, 'h2040);
	addVec(branchWord(OP_BNE, 3, 4, -1), 'h2004, 9'b000_010_000, COND_NE, SIZE_BYTE, 0, 'h2000);
	addVec(branchWord(OP_BLT, 5, 6, 4095), 'h3000, 9'b000_010_000, COND_LT, SIZE_BYTE, 0, 'h6ffc);
	addVec(branchWord(OP_BGE, 7, 8, -4096), 'h8000, 9'b000_010_000, COND_GE, SIZE_BYTE, 0, 'h4000);
	addVec(branchWord(OP_BLTU, 9, 10, 1), 'h500, 9'b000_010_000, COND_LTU, SIZE_BYTE, 0, 'h504);
	addVec(branchWord(OP_BGEU, 11, 12, -16), 'h40, 9'b000_010_000, COND_GEU, SIZE_BYTE, 0, 0);
	// Target wraps past the top of the address space
	addVec(branchWord(OP_BEQ, 13, 14, 8), 64'hffff_ffff_ffff_fff0, 9'b000_010_000,
		COND_EQ, SIZE_BYTE, 0, 'h10);

	// Jumps, the low displacement bits double as rd
	addVec(branchWord(OP_JAL, 0, 0, 20), 'h1000, 9'b000_010_010, COND_ALWAYS, SIZE_BYTE, 0, 'h1050);
	addVec(branchWord(OP_JAL, 0, 0, -64), 'h5000, 9'b000_010_000, COND_ALWAYS, SIZE_BYTE, 0, 'h4f00);
	addVec(immWord(OP_JALR, 31, 5, 12), 'h6000, 9'b000_010_011, COND_ALWAYS, SIZE_BYTE, 12, 0);
	addVec(immWord(OP_JALR, 0, 1, -4), 'h6004, 9'b000_010_001, COND_ALWAYS, SIZE_BYTE, -4, 0);

	// System call alone, then an opcode outside the instruction set
	addVec(immWord(OP_SYS, 0, 0, 0), 'h7000, 9'b000_001_000, COND_EQ, SIZE_BYTE, 0, 0);
	addVec(immWord(7'd100, 1, 2, 3), 'h7004, 9'b000_000_100, COND_EQ, SIZE_BYTE, 0, 0);
endtask

`endif

/* sim/decodeStageTb.sv */
/*
 * Decode stage testbench: clock and reset, table-driven stimulus with random
 * input gaps and output stalls, in-order checking of every bundle, timeout
 */
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

	import isaPkg::*;
	import decodePkg::*;

	localparam int xlen = 64;

	// DUT inputs
	logic                  clk;
	logic                  arstN;
	logic                  inValid;
	logic [instrWidth-1:0] inInstr;
	logic [xlen-1:0]       inPc;
	logic                  outReady;

	// DUT outputs
	logic            inReady;
	logic            outValid;
	logic            outAlu;
	logic            outMem;
	logic            outLoad;
	memSize_t        outMemSize;
	logic            outMemUnsigned;
	logic            outFlow;
	branchCond_t     outBranchCond;
	logic            outSys;
	logic            outIllegal;
	logic            outWritesRd;
	regIdx_t         outRd;
	regIdx_t         outRs1;
	regIdx_t         outRs2;
	logic            outUsesImm;
	logic [xlen-1:0] outImm;
	logic [xlen-1:0] outTarget;
	logic [xlen-1:0] outPc;

	// Stimulus table, filled from the vector file
	logic [instrWidth-1:0] vecInstr[$];
	logic [xlen-1:0]       vecPc[$];
	logic [8:0]            vecFlags[$];
	branchCond_t           vecCond[$];
	memSize_t              vecSize[$];
	logic [xlen-1:0]       vecImm[$];
	logic [xlen-1:0]       vecTarget[$];

	// Rows the DUT has accepted and not yet delivered, oldest first
	int pending[$];

	integer seed;
	int     total;
	int     sent;
	int     checked;
	int     curRow;
	int     cycles = 0;
	int     limit = 0;
	// An offered word was refused and has to stay on the bus
	logic   holding;

	decodeStage #(.xlen(xlen)) u_dut (
		.clk            (clk),
		.arstN          (arstN),
		.inValid        (inValid),
		.inReady        (inReady),
		.inInstr        (inInstr),
		.inPc           (inPc),
		.outReady       (outReady),
		.outValid       (outValid),
		.outAlu         (outAlu),
		.outMem         (outMem),
		.outLoad        (outLoad),
		.outMemSize     (outMemSize),
		.outMemUnsigned (outMemUnsigned),
		.outFlow        (outFlow),
		.outBranchCond  (outBranchCond),
		.outSys         (outSys),
		.outIllegal     (outIllegal),
		.outWritesRd    (outWritesRd),
		.outRd          (outRd),
		.outRs1         (outRs1),
		.outRs2         (outRs2),
		.outUsesImm     (outUsesImm),
		.outImm         (outImm),
		.outTarget      (outTarget),
		.outPc          (outPc)
	);

	always #5 clk = ~clk;

	// ======================================================================
	// Instruction encoders and table loading
	// ======================================================================

	function automatic logic [31:0] r2Word(logic [6:0] fn, regIdx_t rd, regIdx_t rs1,
		regIdx_t rs2);
		return {fn, rs2, rs1, rd, OP_R2};
	endfunction

	// The 13-bit immediate covers the rs2 and function fields
	function automatic logic [31:0] immWord(logic [6:0] op, regIdx_t rd, regIdx_t rs1,
		logic [12:0] imm);
		return {imm, rs1, rd, op};
	endfunction

	// Displacement high bits go in the function field and low bits in rd
	function automatic logic [31:0] branchWord(logic [6:0] op, regIdx_t rs1, regIdx_t rs2,
		logic [12:0] disp);
		return {disp[12:6], rs2, rs1, disp[5:0], op};
	endfunction

	task automatic addVec(logic [31:0] instr, logic [xlen-1:0] pc, logic [8:0] flags,
		branchCond_t cond, memSize_t size, logic [xlen-1:0] imm, logic [xlen-1:0] target);
		vecInstr.push_back(instr);
		vecPc.push_back(pc);
		vecFlags.push_back(flags);
		vecCond.push_back(cond);
		vecSize.push_back(size);
		vecImm.push_back(imm);
		vecTarget.push_back(target);
	endtask

	`include "decodeVectors.svh"

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic reportFailure();
		$display("Simulation FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic checkBit(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: row %0d %s expected %0b, actual %0b",
				$time, curRow, name, expected, actual);
			reportFailure();
		end
	endtask

	task automatic checkReg(string name, regIdx_t expected, regIdx_t actual);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: row %0d %s expected %0d, actual %0d",
				$time, curRow, name, expected, actual);
			reportFailure();
		end
	endtask

	task automatic checkSize(string name, memSize_t expected, memSize_t actual);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: row %0d %s expected %s, actual %s",
				$time, curRow, name, expected.name(), actual.name());
			reportFailure();
		end
	endtask

	task automatic checkCond(string name, branchCond_t expected, branchCond_t actual);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: row %0d %s expected %s, actual %s",
				$time, curRow, name, expected.name(), actual.name());
			reportFailure();
		end
	endtask

	task automatic checkWord(string name, logic [xlen-1:0] expected, logic [xlen-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED at time %0t: row %0d %s expected %h, actual %h",
				$time, curRow, name, expected, actual);
			reportFailure();
		end
	endtask

	// ======================================================================
	// Stimulus and checking
	// ======================================================================

	// Compares the bundle on the output against the oldest accepted row
	task automatic checkOutput();
		logic [instrWidth-1:0] word;
		logic [8:0]            flags;
		regIdx_t               expRd;
		regIdx_t               expRs1;
		regIdx_t               expRs2;
		if (pending.size() == 0)
		begin
			$display("Output handshake at time %0t with no accepted row outstanding", $time);
			reportFailure();
		end
		else
		begin
			curRow = pending.pop_front();
			word   = vecInstr[curRow];
			flags  = vecFlags[curRow];
			// The three register fields sit side by side just above the opcode, rd lowest
			{expRs2, expRs1, expRd} = word[24:7];
			checkWord("outPc", vecPc[curRow], outPc);
			checkBit("outAlu", flags[8], outAlu);
			checkBit("outMem", flags[7], outMem);
			checkBit("outLoad", flags[6], outLoad);
			checkBit("outMemUnsigned", flags[5], outMemUnsigned);
			checkBit("outFlow", flags[4], outFlow);
			checkBit("outSys", flags[3], outSys);
			checkBit("outIllegal", flags[2], outIllegal);
			checkBit("outWritesRd", flags[1], outWritesRd);
			checkBit("outUsesImm", flags[0], outUsesImm);
			checkReg("outRd", expRd, outRd);
			checkReg("outRs1", expRs1, outRs1);
			checkReg("outRs2", expRs2, outRs2);
			checkWord("outImm", vecImm[curRow], outImm);
			if (flags[7])
				checkSize("outMemSize", vecSize[curRow], outMemSize);
			if (flags[4])
			begin
				checkCond("outBranchCond", vecCond[curRow], outBranchCond);
				checkWord("outTarget", vecTarget[curRow], outTarget);
			end
			checked++;
		end
	endtask

	// Runs on the rising edge, so the DUT sees the new values one edge later
	task automatic driveInputs();
		outReady <= (($random(seed) & 3) != 0);
		if (!holding)
		begin
			if (sent < total && (($random(seed) & 3) != 0))
			begin
				inValid <= 1'b1;
				inInstr <= vecInstr[sent];
				inPc    <= vecPc[sent];
			end
			else
				inValid <= 1'b0;
		end
	endtask

	// Runs on the falling edge and records what the next rising edge transfers
	task automatic sampleHandshakes();
		if (outValid && outReady)
			checkOutput();
		if (inValid && inReady)
		begin
			pending.push_back(sent);
			sent++;
		end
		holding = inValid && !inReady;
	endtask

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("Timeout after %0d cycles with %0d of %0d rows checked",
				cycles, checked, total);
			reportFailure();
		end
	end

	initial
	begin
		clk      = 1'b0;
		arstN    = 1'b0;
		inValid  = 1'b0;
		inInstr  = '0;
		inPc     = '0;
		outReady = 1'b0;
		seed     = 32;
		sent     = 0;
		checked  = 0;
		curRow   = -1;
		holding  = 1'b0;
		loadVectors();
		total = vecInstr.size();
		// Random gaps and stalls cost about two cycles a row, eight leaves plenty of margin
		limit = total * 8 + 100;

		repeat (5) @(posedge clk);
		arstN <= 1'b1;

		// Empty register after reset, ready for the first word
		@(negedge clk);
		checkBit("outValid after reset", 1'b0, outValid);
		checkBit("inReady after reset", 1'b1, inReady);

		while (checked < total)
		begin
			@(posedge clk);
			driveInputs();
			@(negedge clk);
			sampleHandshakes();
		end

		// The last bundle retires on the next edge and no extra bundle follows
		@(negedge clk);
		curRow = -1;
		checkBit("outValid after last row", 1'b0, outValid);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/decodeAlu.sv */
/*
 * ALU classifier: flags opcodes and R2 functions that use the integer ALU,
 * including address generation for loads and stores
 */
`timescale 1ns/1ps
`default_nettype none

module decodeAlu (
	input  wire logic [isaPkg::instrWidth-1:0] instr,
	output logic                               alu
);

	import isaPkg::*;

	// Opcode and function fields viewed through their enums
	opcode_t op;
	func_t   fn;

	assign op = opcode_t'(instr[opHi:opLo]);
	assign fn = func_t'(instr[funcHi:funcLo]);

	always_comb
	begin
		case (op)
			// R2 words are ALU work only when the function code is known
			OP_R2:
			begin
				case (fn)
					FN_ADD, FN_SUB, FN_CMP:
						alu = 1'b1;
					FN_MUL, FN_MULU, FN_DIV, FN_DIVU:
						alu = 1'b1;
					FN_AND, FN_OR, FN_EOR, FN_ANDC:
						alu = 1'b1;
					FN_NAND, FN_NOR, FN_ENOR, FN_ORC:
						alu = 1'b1;
					FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
						alu = 1'b1;
					// Unlisted function, which the stage reports as illegal
					default:
						alu = 1'b0;
				endcase
			end

			// Immediate forms of the arithmetic and logic operations
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI:
				alu = 1'b1;
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_SHIFT:
				alu = 1'b1;

			// CSR moves and register moves pass through the ALU
			OP_CSR, OP_MOV:
				alu = 1'b1;

			// NOP occupies an ALU slot that does nothing
			OP_NOP:
				alu = 1'b1;

			// Loads and stores need the ALU to form rs1 plus immediate
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA:
				alu = 1'b1;
			OP_STB, OP_STW, OP_STT, OP_STO:
				alu = 1'b1;

			// System call, flow opcodes and unknown encodings
			default:
				alu = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/decodeFlow.sv */
/*
 * Flow classifier: branches, jumps and the system call, with the
 * branch condition and the pc-relative target
 */
`timescale 1ns/1ps
`default_nettype none

module decodeFlow #(
	parameter int xlen = 64
) (
	input  wire logic [isaPkg::instrWidth-1:0] instr,
	input  wire logic [xlen-1:0]               pc,
	output logic                               flow,
	output logic                               sys,
	output decodePkg::branchCond_t             cond,
	output logic [xlen-1:0]                    target
);

	import isaPkg::*;
	import decodePkg::*;

	opcode_t              op;
	logic [dispWidth-1:0] disp;
	logic [xlen-1:0]      dispExt;
	// Set when the target is known from pc alone
	logic                 pcRel;

	assign op = opcode_t'(instr[opHi:opLo]);

	// Branch words have no rd, so its bits extend the displacement below func
	assign disp = {instr[funcHi:funcLo], instr[rdHi:rdLo]};

	// Sign-extend and scale by four, since instructions are word aligned
	assign dispExt = {{(xlen - dispWidth - 2){disp[dispWidth-1]}}, disp, 2'b00};

	assign sys = (op == OP_SYS);

	always_comb
	begin
		flow  = 1'b1;
		pcRel = 1'b1;
		case (op)
			OP_BEQ:  cond = COND_EQ;
			OP_BNE:  cond = COND_NE;
			OP_BLT:  cond = COND_LT;
			OP_BGE:  cond = COND_GE;
			OP_BLTU: cond = COND_LTU;
			OP_BGEU: cond = COND_GEU;
			OP_JAL:  cond = COND_ALWAYS;
			// Register-indirect jump, the back end adds rs1 and the immediate
			OP_JALR:
			begin
				cond  = COND_ALWAYS;
				pcRel = 1'b0;
			end
			// Not a flow word, the condition is a don't-care left at EQ
			default:
			begin
				flow  = 1'b0;
				pcRel = 1'b0;
				cond  = COND_EQ;
			end
		endcase
	end

	// Target is zero whenever it cannot be formed from the pc
	assign target = pcRel ? (pc + dispExt) : '0;

endmodule

`default_nettype wire

/* source/decodeMem.sv */
/*
 * Memory classifier: recognises loads and stores, and gives
 * access size and signedness of the access
 */
`timescale 1ns/1ps
`default_nettype none

module decodeMem (
	input  wire logic [isaPkg::instrWidth-1:0] instr,
	output logic                               mem,
	output logic                               load,
	output logic                               memUnsigned,
	output decodePkg::memSize_t                memSize
);

	import isaPkg::*;
	import decodePkg::*;

	opcode_t op;

	assign op = opcode_t'(instr[opHi:opLo]);

	always_comb
	begin
		// Non-memory words leave every flag clear and a byte size
		mem         = 1'b0;
		load        = 1'b0;
		memUnsigned = 1'b0;
		memSize     = SIZE_BYTE;

		case (op)
			// Loads, signed forms first and U forms zero-extend
			OP_LDB, OP_LDBU:
			begin
				mem         = 1'b1;
				load        = 1'b1;
				memUnsigned = (op == OP_LDBU);
				memSize     = SIZE_BYTE;
			end
			OP_LDW, OP_LDWU:
			begin
				mem         = 1'b1;
				load        = 1'b1;
				memUnsigned = (op == OP_LDWU);
				memSize     = SIZE_WYDE;
			end
			OP_LDT, OP_LDTU:
			begin
				mem         = 1'b1;
				load        = 1'b1;
				memUnsigned = (op == OP_LDTU);
				memSize     = SIZE_TETRA;
			end
			// An address load fetches a full octa and is treated as unsigned
			OP_LDO, OP_LDA:
			begin
				mem         = 1'b1;
				load        = 1'b1;
				memUnsigned = (op == OP_LDA);
				memSize     = SIZE_OCTA;
			end

			// Stores carry no signedness
			OP_STB:
			begin
				mem     = 1'b1;
				memSize = SIZE_BYTE;
			end
			OP_STW:
			begin
				mem     = 1'b1;
				memSize = SIZE_WYDE;
			end
			OP_STT:
			begin
				mem     = 1'b1;
				memSize = SIZE_TETRA;
			end
			OP_STO:
			begin
				mem     = 1'b1;
				memSize = SIZE_OCTA;
			end

			default:
			begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/decodeOperands.sv */
/*
 * Operand extractor: register indices, register write and immediate use,
 * and the sign-extended immediate
 */
`timescale 1ns/1ps
`default_nettype none

module decodeOperands #(
	parameter int xlen = 64
) (
	input  wire logic [isaPkg::instrWidth-1:0] instr,
	output decodePkg::regIdx_t                 rd,
	output decodePkg::regIdx_t                 rs1,
	output decodePkg::regIdx_t                 rs2,
	output logic                               writesRd,
	output logic                               usesImm,
	output logic [xlen-1:0]                    imm
);

	import isaPkg::*;

	opcode_t op;
	// Result class before the rd of zero check
	logic    hasResult;

	assign op = opcode_t'(instr[opHi:opLo]);

	// Register fields go out unmasked, even for formats that reuse them
	assign rd  = instr[rdHi:rdLo];
	assign rs1 = instr[rs1Hi:rs1Lo];
	assign rs2 = instr[rs2Hi:rs2Lo];

	always_comb
	begin
		hasResult = 1'b0;
		usesImm   = 1'b0;
		case (op)
			OP_R2, OP_CSR, OP_MOV:
				hasResult = 1'b1;
			// Shift amount comes from the immediate like the other I forms
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_SHIFT:
			begin
				hasResult = 1'b1;
				usesImm   = 1'b1;
			end
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA:
			begin
				hasResult = 1'b1;
				usesImm   = 1'b1;
			end
			// Stores only add the immediate to the base address
			OP_STB, OP_STW, OP_STT, OP_STO:
				usesImm = 1'b1;
			// Jumps write the link address
			OP_JAL:
				hasResult = 1'b1;
			OP_JALR:
			begin
				hasResult = 1'b1;
				usesImm   = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// Writes to register 0 are discarded here so the back end never sees them
	assign writesRd = hasResult && (rd != '0);

	// Sign-extended immediate, forced to zero for formats without one
	assign imm = usesImm ? {{(xlen - immWidth){instr[immHi]}}, instr[immHi:immLo]} : '0;

endmodule

`default_nettype wire

/* source/decodePkg.sv */
/*
 * Decoded bundle types: register index, memory access size
 * and branch condition
 */
`default_nettype none

package decodePkg;

	// Register index, register 0 always reads as zero
	typedef logic [5:0] regIdx_t;

	// Access size of a load or store
	typedef enum logic [1:0] {
		// One byte
		SIZE_BYTE  = 2'd0,
		// Two bytes
		SIZE_WYDE  = 2'd1,
		// Four bytes
		SIZE_TETRA = 2'd2,
		// Eight bytes
		SIZE_OCTA  = 2'd3
	} memSize_t;

	// Condition the back end evaluates on rs1 and rs2 before taking a branch
	typedef enum logic [2:0] {
		COND_EQ     = 3'd0,
		COND_NE     = 3'd1,
		COND_LT     = 3'd2,
		COND_GE     = 3'd3,
		COND_LTU    = 3'd4,
		COND_GEU    = 3'd5,
		// Jumps are taken without a compare
		COND_ALWAYS = 3'd7
	} branchCond_t;

endpackage

`default_nettype wire

/* source/decodeStage.sv */
/*
 * Decode stage top: the four combinational decoders, illegal detection
 * and the one-entry valid/ready output register
 */
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
	parameter int xlen = 64
) (
	input  wire logic                               clk,
	input  wire logic                               arstN,
	// Instruction input handshake
	input  wire logic                               inValid,
	output logic                                    inReady,
	input  wire logic [isaPkg::instrWidth-1:0]      inInstr,
	input  wire logic [xlen-1:0]                    inPc,
	// Decoded bundle output handshake
	input  wire logic                               outReady,
	output logic                                    outValid,
	output logic                                    outAlu,
	output logic                                    outMem,
	output logic                                    outLoad,
	output decodePkg::memSize_t                     outMemSize,
	output logic                                    outMemUnsigned,
	output logic                                    outFlow,
	output decodePkg::branchCond_t                  outBranchCond,
	output logic                                    outSys,
	output logic                                    outIllegal,
	output logic                                    outWritesRd,
	output decodePkg::regIdx_t                      outRd,
	output decodePkg::regIdx_t                      outRs1,
	output decodePkg::regIdx_t                      outRs2,
	output logic                                    outUsesImm,
	output logic [xlen-1:0]                         outImm,
	output logic [xlen-1:0]                         outTarget,
	output logic [xlen-1:0]                         outPc
);

	import decodePkg::*;

	// Combinational decode results for the word on the input
	logic        aluHit;
	logic        memHit;
	logic        loadHit;
	memSize_t    memSize;
	logic        memUnsigned;
	logic        flowHit;
	logic        sysHit;
	branchCond_t cond;
	logic        illegal;
	logic        writesRd;
	regIdx_t     rd;
	regIdx_t     rs1;
	regIdx_t     rs2;
	logic        usesImm;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] target;
	// Input word taken this cycle
	logic        accept;

	// ======================================================================
	// Decoders
	// ======================================================================

	decodeAlu u_alu (
		.instr (inInstr),
		.alu   (aluHit)
	);

	decodeMem u_mem (
		.instr       (inInstr),
		.mem         (memHit),
		.load        (loadHit),
		.memUnsigned (memUnsigned),
		.memSize     (memSize)
	);

	decodeFlow #(.xlen(xlen)) u_flow (
		.instr  (inInstr),
		.pc     (inPc),
		.flow   (flowHit),
		.sys    (sysHit),
		.cond   (cond),
		.target (target)
	);

	decodeOperands #(.xlen(xlen)) u_operands (
		.instr    (inInstr),
		.rd       (rd),
		.rs1      (rs1),
		.rs2      (rs2),
		.writesRd (writesRd),
		.usesImm  (usesImm),
		.imm      (imm)
	);

	// Memory words are a subset of ALU work, so three classes cover every legal word
	assign illegal = !(aluHit || flowHit || sysHit);

	// ======================================================================
	// Output register
	// ======================================================================

	// The register can take a new word when it is empty or being drained this cycle
	assign inReady = !outValid || outReady;
	assign accept  = inValid && inReady;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (accept)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// Bundle only loads on acceptance, so it holds steady through a stall
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			outAlu         <= aluHit;
			outMem         <= memHit;
			outLoad        <= loadHit;
			outMemSize     <= memSize;
			outMemUnsigned <= memUnsigned;
			outFlow        <= flowHit;
			outBranchCond  <= cond;
			outSys         <= sysHit;
			outIllegal     <= illegal;
			outWritesRd    <= writesRd;
			outRd          <= rd;
			outRs1         <= rs1;
			outRs2         <= rs2;
			outUsesImm     <= usesImm;
			outImm         <= imm;
			outTarget      <= target;
			outPc          <= inPc;
		end
	end

endmodule

`default_nettype wire

/* source/isaPkg.sv */
/*
 * Instruction set definitions: word geometry, field positions,
 * the primary opcode enum and the R2 function code enum
 */
`default_nettype none

package isaPkg;

	// ======================================================================
	// Word geometry and field positions
	// ======================================================================

	// Every instruction is a single fixed-size word
	localparam int instrWidth = 32;

	// Primary opcode sits in the low seven bits
	localparam int opLo = 0;
	localparam int opHi = 6;

	// Register fields, six bits each for a 64-entry register file
	localparam int rdLo  = 7;
	localparam int rdHi  = 12;
	localparam int rs1Lo = 13;
	localparam int rs1Hi = 18;
	localparam int rs2Lo = 19;
	localparam int rs2Hi = 24;

	// Function code of R2 words, which also forms the top of a branch displacement
	localparam int funcLo = 25;
	localparam int funcHi = 31;

	// The immediate overlaps rs2 and the function field
	localparam int immLo    = 19;
	localparam int immHi    = 31;
	localparam int immWidth = 13;

	// Branch displacement is func joined with rd, counted in words
	localparam int dispWidth = 13;

	// ======================================================================
	// Opcodes
	// ======================================================================

	typedef enum logic [6:0] {
		OP_SYS   = 7'd0,
		OP_R2    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_SUBFI = 7'd5,
		OP_CMPI  = 7'd6,
		OP_MULI  = 7'd7,
		OP_DIVI  = 7'd8,
		OP_ANDI  = 7'd9,
		OP_ORI   = 7'd10,
		OP_EORI  = 7'd11,
		OP_SLTI  = 7'd12,
		OP_SHIFT = 7'd13,
		OP_CSR   = 7'd14,
		OP_MOV   = 7'd15,
		OP_NOP   = 7'd31,
		OP_JAL   = 7'd40,
		OP_JALR  = 7'd41,
		OP_BEQ   = 7'd42,
		OP_BNE   = 7'd43,
		OP_BLT   = 7'd44,
		OP_BGE   = 7'd45,
		OP_BLTU  = 7'd46,
		OP_BGEU  = 7'd47,
		OP_LDB   = 7'd64,
		OP_LDBU  = 7'd65,
		OP_LDW   = 7'd66,
		OP_LDWU  = 7'd67,
		OP_LDT   = 7'd68,
		OP_LDTU  = 7'd69,
		OP_LDO   = 7'd70,
		OP_LDA   = 7'd71,
		OP_STB   = 7'd72,
		OP_STW   = 7'd73,
		OP_STT   = 7'd74,
		OP_STO   = 7'd75
	} opcode_t;

	// Function codes of the R2 register-register format
	typedef enum logic [6:0] {
		FN_CMP  = 7'd3,
		FN_ADD  = 7'd4,
		FN_SUB  = 7'd5,
		FN_MUL  = 7'd6,
		FN_AND  = 7'd8,
		FN_OR   = 7'd9,
		FN_EOR  = 7'd10,
		FN_ANDC = 7'd11,
		FN_NAND = 7'd12,
		FN_NOR  = 7'd13,
		FN_MULU = 7'd14,
		FN_ENOR = 7'd15,
		FN_DIV  = 7'd16,
		FN_DIVU = 7'd17,
		FN_ORC  = 7'd18,
		FN_SEQ  = 7'd24,
		FN_SNE  = 7'd25,
		FN_SLT  = 7'd26,
		FN_SLE  = 7'd27,
		FN_SLTU = 7'd28,
		FN_SLEU = 7'd29
	} func_t;

endpackage

`default_nettype wire

/* src.f */
+incdir+sim
source/isaPkg.sv
source/decodePkg.sv
source/decodeAlu.sv
source/decodeMem.sv
source/decodeFlow.sv
source/decodeOperands.sv
source/decodeStage.sv
sim/decodeStageTb.sv
